// ==== all.f ====
+incdir+sim
verilog/rpg_pkg.sv
verilog/rpg_seg_if.sv
verilog/rpg_seg_ctrl.sv
verilog/rpg_hdr_fmt.sv
verilog/rpg_byte_packer.sv
verilog/resp_pkt_gen.sv
sim/tb_resp_pkt_gen.sv

// ==== Bender.yml ====
package:
  name: resp_pkt_gen

sources:
  - files:
      - verilog/rpg_pkg.sv
      - verilog/rpg_seg_if.sv
      - verilog/rpg_seg_ctrl.sv
      - verilog/rpg_hdr_fmt.sv
      - verilog/rpg_byte_packer.sv
      - verilog/resp_pkt_gen.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_resp_pkt_gen.sv

// ==== sim/tb_rpg_model.svh ====
`ifndef TB_RPG_MODEL_SVH
`define TB_RPG_MODEL_SVH

// descriptor bit ranges are psn 23:0, dest qp 47:24, pkey 63:48, opcode 71:64,
// pmtu code 79:72, msg size 111:80, aeth 143:112
logic [7:0] pkt_bytes[$];

function automatic int mtu_for_code(input logic [7:0] code);
    case (code)
        8'd2:    return 512;
        8'd3:    return 1024;
        8'd4:    return 2048;
        8'd5:    return 4096;
        default: return 256;
    endcase
endfunction

function automatic int words_for(input logic [rpg_pkg::MD_W-1:0] md);
    int left;
    int pl;
    int n;
    n    = 0;
    left = (md[71:64] == 8'h11) ? 0 : int'(md[111:80]);
    while (left > 0) begin
        pl = (left > mtu_for_code(md[79:72])) ? mtu_for_code(md[79:72]) : left;
        n += (pl + 31) / 32;   // each packet starts on a fresh word
        left -= pl;
    end
    return n;
endfunction

task automatic push_header(input logic [7:0] op, input logic [rpg_pkg::MD_W-1:0] md,
                           input logic [23:0] psn, input bit with_aeth);
    logic [127:0] h;
    h = {md[143:112], psn, 8'h00, md[47:24], 8'h00, md[63:48], 8'h00, op};
    for (int i = 0; i < (with_aeth ? 16 : 12); i++) begin
        pkt_bytes.push_back(h[8*i +: 8]);
    end
endtask

task automatic emit_beats();
    logic [rpg_pkg::BEAT_W-1:0] beat;
    while (pkt_bytes.size() != 0) begin
        beat = '0;   // zero fill past packet end
        for (int j = 0; j < 32 && pkt_bytes.size() != 0; j++) begin
            beat[8*j +: 8] = pkt_bytes.pop_front();
        end
        exp_beats.push_back(beat);
    end
endtask

task automatic build_beats(input logic [rpg_pkg::MD_W-1:0] md, input int base);
    logic [rpg_pkg::BEAT_W-1:0] w;
    logic [23:0] psn;
    logic [7:0]  op;
    int          mtu;
    int          left;
    int          pl;
    int          idx;
    bit          first;
    psn   = md[23:0];
    mtu   = mtu_for_code(md[79:72]);
    idx   = base;
    first = 1'b1;
    if (md[71:64] == 8'h11) begin
        push_header(md[71:64], md, psn, 1'b1);   // ack header as given
        emit_beats();
    end
    left = (md[71:64] == 8'h11) ? 0 : int'(md[111:80]);
    while (left > 0) begin
        pl = (left > mtu) ? mtu : left;
        if (first) begin
            op = (left <= mtu) ? 8'h10 : 8'h0D;
        end else begin
            op = (left <= mtu) ? 8'h0F : 8'h0E;
        end
        push_header(op, md, psn, op != 8'h0E);   // middle is bth only
        for (int k = 0; k < pl; k++) begin
            w = nd_q[idx + k / 32];
            pkt_bytes.push_back(w[8*(k%32) +: 8]);
        end
        emit_beats();
        idx += (pl + 31) / 32;
        psn = psn + 24'd1;
        left -= pl;
        first = 1'b0;
    end
endtask

`endif

// ==== sim/tb_resp_pkt_gen.sv ====
`default_nettype none

module tb_resp_pkt_gen;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_DESC = 40;

    logic                        clk;
    logic                        rst;
    logic                        i_md_empty;
    logic [rpg_pkg::MD_W-1:0]    i_md_data;
    logic                        o_md_rd_en;
    logic                        i_nd_empty;
    logic [rpg_pkg::BEAT_W-1:0]  i_nd_data;
    logic                        o_nd_rd_en;
    logic                        i_trans_prog_full;
    logic                        o_trans_wr_en;
    logic [rpg_pkg::BEAT_W-1:0]  o_trans_data;

    logic [31:0]                 lfsr;
    logic [rpg_pkg::MD_W-1:0]    md_q[$];
    logic [rpg_pkg::BEAT_W-1:0]  nd_q[$];
    logic [rpg_pkg::BEAT_W-1:0]  exp_beats[$];
    int                          exp_words[$];
    int                          words_seen;
    int                          beat_cnt;
    int                          desc_cnt;
    int                          timeout_cycles;
    logic                        gen_done;

    `include "tb_rpg_model.svh"

    resp_pkt_gen u_dut (
        .clk               (clk),
        .rst               (rst),
        .i_md_empty        (i_md_empty),
        .i_md_data         (i_md_data),
        .o_md_rd_en        (o_md_rd_en),
        .i_nd_empty        (i_nd_empty),
        .i_nd_data         (i_nd_data),
        .o_nd_rd_en        (o_nd_rd_en),
        .i_trans_prog_full (i_trans_prog_full),
        .o_trans_wr_en     (o_trans_wr_en),
        .o_trans_data      (o_trans_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic fail_with(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [255:0] exp, input logic [255:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic gen_stimulus();
        logic [rpg_pkg::MD_W-1:0]   md;
        logic [rpg_pkg::BEAT_W-1:0] w;
        int                         nw;
        int                         total_bytes;
        total_bytes = 0;
        for (int d = 0; d < N_DESC; d++) begin
            md           = '0;
            md[23:0]     = 24'(rand_bits(24));
            md[47:24]    = 24'(rand_bits(24));
            md[63:48]    = 16'(rand_bits(16));
            md[71:64]    = (rand_bits(2) == 0) ? 8'h11 : 8'(rand_bits(8));
            md[79:72]    = 8'(rand_bits(3));
            md[111:80]   = rand_bits(11) % 1500 + 1;
            md[143:112]  = rand_bits(32);
            if (md[71:64] == 8'h11 && md[0]) begin
                md[71:64] = 8'h0C;   // about one in eight stays ack
            end
            nw = words_for(md);
            for (int k = 0; k < nw; k++) begin
                for (int b = 0; b < 8; b++) begin
                    w[32*b +: 32] = rand_bits(32);
                end
                nd_q.push_back(w);
            end
            build_beats(md, nd_q.size() - nw);
            exp_words.push_back(nw);
            md_q.push_back(md);
            total_bytes += int'(md[111:80]);
        end
        timeout_cycles = 8 * (total_bytes / 32 + 24 * N_DESC) + 500;
    endtask

    task automatic step_cycle();
        @(negedge clk);
        i_md_empty        = (md_q.size() == 0);
        i_md_data         = (md_q.size() != 0) ? md_q[0] : '0;
        i_nd_empty        = (nd_q.size() == 0) || (rand_bits(2) == 0);  // random gaps
        i_nd_data         = (nd_q.size() != 0) ? nd_q[0] : '0;
        i_trans_prog_full = (rand_bits(2) == 0);
        #1;
        if (o_trans_wr_en) begin
            if (exp_beats.size() == 0) begin
                fail_with("a beat was written with no expected beat left");
            end else begin
                check_eq($sformatf("beat %0d", beat_cnt), exp_beats.pop_front(), o_trans_data);
                beat_cnt++;
            end
        end
        if (o_nd_rd_en) begin
            if (i_nd_empty) begin
                fail_with("the payload FIFO was popped while empty");
            end
            void'(nd_q.pop_front());
            words_seen++;
        end
        if (o_md_rd_en) begin
            if (i_md_empty) begin
                fail_with("the metadata FIFO was popped while empty");
            end
            check_eq($sformatf("payload words of descriptor %0d", desc_cnt),
                     exp_words.pop_front(), words_seen);
            words_seen = 0;
            void'(md_q.pop_front());
            desc_cnt++;
        end
    endtask

    initial begin
        rst               = 1'b1;
        i_md_empty        = 1'b1;
        i_md_data         = '0;
        i_nd_empty        = 1'b1;
        i_nd_data         = '0;
        i_trans_prog_full = 1'b0;
        lfsr              = 32'd63;
        words_seen        = 0;
        beat_cnt          = 0;
        desc_cnt          = 0;
        gen_done          = 1'b0;
        gen_stimulus();
        gen_done = 1'b1;
        repeat (3) begin
            @(negedge clk);
            i_md_empty = (md_q.size() == 0);   // loaded fifos, nothing may pop in reset
            i_md_data  = (md_q.size() != 0) ? md_q[0] : '0;
            i_nd_empty = (nd_q.size() == 0);
            i_nd_data  = (nd_q.size() != 0) ? nd_q[0] : '0;
            #1;
            check_eq("strobes in reset", '0, {o_md_rd_en, o_nd_rd_en, o_trans_wr_en});
        end
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_eq("strobes after reset", '0, {o_md_rd_en, o_nd_rd_en, o_trans_wr_en});
        while (md_q.size() != 0) begin
            step_cycle();
        end
        repeat (8) step_cycle();   // last flush beat lands after the pop
        if (exp_beats.size() != 0 || nd_q.size() != 0) begin
            $display("expected beats or payload words were left over at the end");
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    initial begin
        wait (gen_done);
        #(timeout_cycles * 4);
        $display("timeout after %0d cycles with descriptors still pending", timeout_cycles);
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== verilog/resp_pkt_gen.sv ====
`default_nettype none

module resp_pkt_gen (
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire logic                        i_md_empty,
    input  wire logic [rpg_pkg::MD_W-1:0]    i_md_data,
    output logic                             o_md_rd_en,

    input  wire logic                        i_nd_empty,
    input  wire logic [rpg_pkg::BEAT_W-1:0]  i_nd_data,
    output logic                             o_nd_rd_en,

    input  wire logic                        i_trans_prog_full,
    output logic                             o_trans_wr_en,
    output logic [rpg_pkg::BEAT_W-1:0]       o_trans_data
);

    rpg_pkg::rpg_kind_e         kind;
    logic                       load;
    rpg_pkg::rpg_hdr_t          hdr;
    logic [rpg_pkg::RES_W-1:0]  hdr_len;

    rpg_seg_if seg_bus ();

    rpg_seg_ctrl u_seg_ctrl (
        .clk               (clk),
        .rst               (rst),
        .i_md_empty        (i_md_empty),
        .i_md_data         (i_md_data),
        .i_nd_empty        (i_nd_empty),
        .i_trans_prog_full (i_trans_prog_full),
        .o_md_rd_en        (o_md_rd_en),
        .o_nd_rd_en        (o_nd_rd_en),
        .o_kind            (kind),
        .o_load            (load),
        .seg               (seg_bus.ctrl)
    );

    // descriptor stays on the fifo head until popped
    rpg_hdr_fmt u_hdr_fmt (
        .clk       (clk),
        .rst       (rst),
        .i_md      (i_md_data),
        .i_kind    (kind),
        .i_load    (load),
        .o_hdr     (hdr),
        .o_hdr_len (hdr_len)
    );

    rpg_byte_packer u_byte_packer (
        .clk           (clk),
        .rst           (rst),
        .i_hdr         (hdr),
        .i_hdr_len     (hdr_len),
        .i_nd_data     (i_nd_data),
        .seg           (seg_bus.packer),
        .o_trans_wr_en (o_trans_wr_en),
        .o_trans_data  (o_trans_data)
    );

endmodule

`default_nettype wire

// ==== verilog/rpg_byte_packer.sv ====
`default_nettype none

module rpg_byte_packer (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire rpg_pkg::rpg_hdr_t       i_hdr,
    input  wire logic [rpg_pkg::RES_W-1:0] i_hdr_len,
    input  wire logic [rpg_pkg::BEAT_W-1:0] i_nd_data,
    rpg_seg_if.packer                    seg,
    output logic                         o_trans_wr_en,
    output logic [rpg_pkg::BEAT_W-1:0]   o_trans_data
);

    logic [rpg_pkg::RES_W-1:0]    res_cnt;
    logic [rpg_pkg::BEAT_W-1:0]   res_data;   // bytes above res_cnt kept at zero
    logic                         flush_pend;
    logic [rpg_pkg::BEAT_W-1:0]   nd_keep;
    logic [2*rpg_pkg::BEAT_W-1:0] merged;
    logic [rpg_pkg::RES_W-1:0]    sum;
    logic                         beat_full;
    logic                         do_take;
    logic                         flush;

    assign seg.busy = flush_pend;

    // drop bytes of the word past the packet end
    assign nd_keep = i_nd_data &
                     ({rpg_pkg::BEAT_W{1'b1}} >> ((rpg_pkg::BEAT_BYTES - seg.take_bytes) * 8));

    // new bytes land right behind the residue
    assign merged = ({{rpg_pkg::BEAT_W{1'b0}}, nd_keep} << {res_cnt, 3'b000}) |
                    {{rpg_pkg::BEAT_W{1'b0}}, res_data};

    assign sum       = res_cnt + seg.take_bytes;
    assign beat_full = (sum >= rpg_pkg::BEAT_BYTES);
    assign do_take   = seg.take && !seg.load;
    assign flush     = seg.last && flush_pend && !seg.take && !seg.load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_cnt       <= '0;
            flush_pend    <= 1'b0;
            o_trans_wr_en <= 1'b0;
        end else begin
            o_trans_wr_en <= 1'b0;
            if (seg.load) begin
                res_cnt    <= i_hdr_len;
                flush_pend <= seg.last;   // header only packet
            end else if (do_take) begin
                if (beat_full) begin
                    o_trans_wr_en <= 1'b1;
                    res_cnt       <= sum - rpg_pkg::BEAT_BYTES[rpg_pkg::RES_W-1:0];
                    flush_pend    <= seg.last && (sum != rpg_pkg::BEAT_BYTES);
                end else begin
                    res_cnt    <= sum;
                    flush_pend <= seg.last;
                end
            end else if (flush) begin
                o_trans_wr_en <= 1'b1;
                res_cnt       <= '0;
                flush_pend    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seg.load) begin
            res_data <= {{(rpg_pkg::BEAT_W - $bits(i_hdr)){1'b0}}, i_hdr};
        end else if (do_take) begin
            res_data <= beat_full ? merged[2*rpg_pkg::BEAT_W-1:rpg_pkg::BEAT_W] :
                                    merged[rpg_pkg::BEAT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (do_take && beat_full) begin
            o_trans_data <= merged[rpg_pkg::BEAT_W-1:0];
        end else if (flush) begin
            o_trans_data <= res_data;   // zero filled tail
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rpg_hdr_fmt.sv ====
`default_nettype none

module rpg_hdr_fmt (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rpg_pkg::rpg_md_t      i_md,
    input  wire rpg_pkg::rpg_kind_e    i_kind,
    input  wire logic                  i_load,
    output rpg_pkg::rpg_hdr_t          o_hdr,
    output logic [rpg_pkg::RES_W-1:0]  o_hdr_len
);

    logic [23:0] psn_cnt;   // psn of the next middle or last packet
    logic [23:0] psn_sel;
    logic        use_md_psn;

    assign use_md_psn = (i_kind == rpg_pkg::KIND_ACK) ||
                        (i_kind == rpg_pkg::KIND_FIRST) ||
                        (i_kind == rpg_pkg::KIND_ONLY);
    assign psn_sel = use_md_psn ? i_md.psn : psn_cnt;

    always_comb begin
        o_hdr         = '0;
        o_hdr.pkey    = i_md.pkey;
        o_hdr.dest_qp = i_md.dest_qp;
        o_hdr.psn     = psn_sel;
        o_hdr.aeth    = i_md.aeth;
        o_hdr_len     = rpg_pkg::HDR_FULL_BYTES[rpg_pkg::RES_W-1:0];
        case (i_kind)
            rpg_pkg::KIND_FIRST: o_hdr.opcode = rpg_pkg::OP_READ_FIRST;
            rpg_pkg::KIND_LAST:  o_hdr.opcode = rpg_pkg::OP_READ_LAST;
            rpg_pkg::KIND_ONLY:  o_hdr.opcode = rpg_pkg::OP_READ_ONLY;
            rpg_pkg::KIND_MIDDLE: begin
                o_hdr.opcode = rpg_pkg::OP_READ_MIDDLE;
                o_hdr.aeth   = '0;  // bth only
                o_hdr_len    = rpg_pkg::HDR_BTH_BYTES[rpg_pkg::RES_W-1:0];
            end
            default: o_hdr.opcode = i_md.opcode;  // ack goes out as given
        endcase
    end

    // wraps at 2^24 by width
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psn_cnt <= '0;
        end else if (i_load && (i_kind != rpg_pkg::KIND_ACK)) begin
            psn_cnt <= psn_sel + 24'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rpg_seg_ctrl.sv ====
`default_nettype none

module rpg_seg_ctrl (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               i_md_empty,
    input  wire rpg_pkg::rpg_md_t   i_md_data,
    input  wire logic               i_nd_empty,
    input  wire logic               i_trans_prog_full,
    output logic                    o_md_rd_en,
    output logic                    o_nd_rd_en,
    output rpg_pkg::rpg_kind_e      o_kind,
    output logic                    o_load,
    rpg_seg_if.ctrl                 seg
);

    rpg_pkg::rpg_state_e             state;
    rpg_pkg::rpg_state_e             state_nxt;
    logic [rpg_pkg::LEN_W-1:0]       msg_left;
    logic [rpg_pkg::LEN_W-1:0]       pkt_left;
    logic [rpg_pkg::LEN_W-1:0]       pmtu;
    logic [rpg_pkg::LEN_W-1:0]       pkt_len;
    logic                            first_pkt;
    logic                            fits;
    logic                            is_ack;
    logic                            pkt_end;
    logic                            flush;
    logic                            drain_done;

    assign pmtu      = rpg_pkg::pmtu_bytes(i_md_data.pmtu_code);
    assign is_ack    = (i_md_data.opcode == rpg_pkg::OP_ACK);
    assign first_pkt = (msg_left == i_md_data.msg_size); // nothing sent yet
    assign fits      = (msg_left <= pmtu);
    assign pkt_len   = fits ? msg_left : pmtu;
    assign pkt_end   = (pkt_left <= rpg_pkg::BEAT_BYTES);

    always_comb begin
        if (state == rpg_pkg::ST_ACK) begin
            o_kind = rpg_pkg::KIND_ACK;
        end else if (first_pkt && fits) begin
            o_kind = rpg_pkg::KIND_ONLY;
        end else if (first_pkt) begin
            o_kind = rpg_pkg::KIND_FIRST;
        end else if (fits) begin
            o_kind = rpg_pkg::KIND_LAST;
        end else begin
            o_kind = rpg_pkg::KIND_MIDDLE;
        end
    end

    assign o_load   = (state == rpg_pkg::ST_ACK) || (state == rpg_pkg::ST_SEG);
    assign seg.load = o_load;

    // one word per cycle unless starved or stalled
    assign seg.take = (state == rpg_pkg::ST_PAYLOAD) && !i_nd_empty && !i_trans_prog_full;
    assign seg.take_bytes = (pkt_left >= rpg_pkg::BEAT_BYTES) ?
                            rpg_pkg::BEAT_BYTES[rpg_pkg::RES_W-1:0] :
                            pkt_left[rpg_pkg::RES_W-1:0];
    assign o_nd_rd_en = seg.take;

    // let the packer write its leftover bytes when the output is free
    assign flush      = (state == rpg_pkg::ST_DRAIN) && seg.busy && !i_trans_prog_full;
    assign drain_done = (state == rpg_pkg::ST_DRAIN) && (!seg.busy || !i_trans_prog_full);

    assign seg.last   = (state == rpg_pkg::ST_ACK) || (seg.take && pkt_end) || flush;
    assign o_md_rd_en = drain_done && (msg_left == '0);

    always_comb begin
        state_nxt = state;
        case (state)
            rpg_pkg::ST_IDLE: begin
                if (!i_md_empty) begin
                    state_nxt = is_ack ? rpg_pkg::ST_ACK : rpg_pkg::ST_SEG;
                end
            end
            rpg_pkg::ST_ACK: state_nxt = rpg_pkg::ST_DRAIN;
            rpg_pkg::ST_SEG: state_nxt = rpg_pkg::ST_PAYLOAD;
            rpg_pkg::ST_PAYLOAD: begin
                if (seg.take && pkt_end) begin
                    state_nxt = rpg_pkg::ST_DRAIN;
                end
            end
            rpg_pkg::ST_DRAIN: begin
                if (drain_done) begin
                    state_nxt = (msg_left == '0) ? rpg_pkg::ST_IDLE : rpg_pkg::ST_SEG;
                end
            end
            default: state_nxt = rpg_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= rpg_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            msg_left <= '0;
            pkt_left <= '0;
        end else begin
            case (state)
                rpg_pkg::ST_IDLE: begin
                    if (!i_md_empty) begin
                        msg_left <= is_ack ? '0 : i_md_data.msg_size;
                    end
                end
                rpg_pkg::ST_SEG: begin
                    msg_left <= msg_left - pkt_len;  // whole packet booked up front
                    pkt_left <= pkt_len;
                end
                rpg_pkg::ST_PAYLOAD: begin
                    if (seg.take) begin
                        pkt_left <= pkt_left - seg.take_bytes;
                    end
                end
                default: begin
                    pkt_left <= pkt_left;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rpg_seg_if.sv ====
`default_nettype none

// segment controller to byte packer
interface rpg_seg_if;

    logic                      load;       // start packet with header into residue
    logic                      take;       // payload word popped this cycle
    logic [rpg_pkg::RES_W-1:0] take_bytes; // 1..32 valid bytes of that word
    logic                      last;       // no more payload for this packet
    logic                      busy;       // residue of a finished packet not yet written

    modport ctrl (
        output load,
        output take,
        output take_bytes,
        output last,
        input  busy
    );

    modport packer (
        input  load,
        input  take,
        input  take_bytes,
        input  last,
        output busy
    );

endinterface

`default_nettype wire

// ==== verilog/rpg_pkg.sv ====
`default_nettype none

package rpg_pkg;

    localparam int BEAT_BYTES     = 32;
    localparam int BEAT_W         = 256;
    localparam int MD_W           = 192;
    localparam int LEN_W          = 32;
    localparam int RES_W          = 6;    // holds 0..63 for residue plus one word
    localparam int HDR_FULL_BYTES = 16;   // BTH + AETH
    localparam int HDR_BTH_BYTES  = 12;

    typedef enum logic [7:0] {
        OP_READ_FIRST  = 8'h0D,
        OP_READ_MIDDLE = 8'h0E,
        OP_READ_LAST   = 8'h0F,
        OP_READ_ONLY   = 8'h10,
        OP_ACK         = 8'h11
    } rpg_opcode_e;

    typedef enum logic [2:0] {
        KIND_ACK,
        KIND_FIRST,
        KIND_MIDDLE,
        KIND_LAST,
        KIND_ONLY
    } rpg_kind_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACK,
        ST_SEG,
        ST_PAYLOAD,
        ST_DRAIN
    } rpg_state_e;

    typedef struct packed {
        logic [47:0] rsvd;
        logic [31:0] aeth;
        logic [31:0] msg_size;
        logic [7:0]  pmtu_code;
        logic [7:0]  opcode;
        logic [15:0] pkey;
        logic [23:0] dest_qp;
        logic [23:0] psn;
    } rpg_md_t;

    // byte 0 sits in the low bits with fields little endian
    typedef struct packed {
        logic [31:0] aeth;    // bytes 12..15
        logic [23:0] psn;     // bytes 9..11
        logic [7:0]  rsvd2;
        logic [23:0] dest_qp; // bytes 5..7
        logic [7:0]  rsvd1;
        logic [15:0] pkey;    // bytes 2..3
        logic [7:0]  rsvd0;
        logic [7:0]  opcode;
    } rpg_hdr_t;

    function automatic logic [LEN_W-1:0] pmtu_bytes(input logic [7:0] code);
        logic [LEN_W-1:0] bytes;
        case (code)
            8'd1:    bytes = 32'd256;
            8'd2:    bytes = 32'd512;
            8'd3:    bytes = 32'd1024;
            8'd4:    bytes = 32'd2048;
            8'd5:    bytes = 32'd4096;
            default: bytes = 32'd256;   // unknown code falls back to smallest mtu
        endcase
        return bytes;
    endfunction

endpackage

`default_nettype wire
